// File: rtl/cpu_pkg.sv
package cpu_pkg;

    // machine word width
    // the instruction layout below is carved out of it
    localparam int DATA_WIDTH = 16;

    // instruction classes
    // 4'hb to 4'he are unassigned and run as nop
    typedef enum logic [3:0] {
        OP_HLT = 4'h0,
        OP_LDA = 4'h1,
        OP_STA = 4'h2,
        OP_ADD = 4'h3,
        OP_SUB = 4'h4,
        OP_AND = 4'h5,
        OP_OR  = 4'h6,
        OP_XOR = 4'h7,
        OP_JMP = 4'h8,
        OP_JZ  = 4'h9,
        OP_OUT = 4'ha,
        OP_OPI = 4'hf
    } opcode_t;

    // alu function select, full 16 entries
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_MUL  = 4'h2,
        ALU_DIV  = 4'h3,
        ALU_SHL  = 4'h4,
        ALU_SHR  = 4'h5,
        ALU_ROL  = 4'h6,
        ALU_ROR  = 4'h7,
        ALU_AND  = 4'h8,
        ALU_OR   = 4'h9,
        ALU_XOR  = 4'ha,
        ALU_NOR  = 4'hb,
        ALU_NAND = 4'hc,
        ALU_XNOR = 4'hd,
        ALU_GT   = 4'he,
        ALU_EQ   = 4'hf
    } alu_fn_t;

    // one instruction word seen two ways
    typedef union packed {
        // memory form, opcode plus word address
        struct packed {
            opcode_t               opcode;
            logic [DATA_WIDTH-5:0] addr;
        } mem;
        // immediate form, opcode, alu function, zero-extended byte
        struct packed {
            opcode_t               opcode;
            alu_fn_t               fn;
            logic [DATA_WIDTH-9:0] imm;
        } imm;
    } instr_t;

    // sequencer states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_FETCH     = 3'd1,
        ST_DECODE    = 3'd2,
        ST_EXECUTE   = 3'd3,
        ST_WRITEBACK = 3'd4,
        ST_HALTED    = 3'd5
    } state_t;

endpackage

// File: rtl/alu.sv
module alu (
    input  cpu_pkg::alu_fn_t                fn,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  a,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  mem_word,
    input  logic [cpu_pkg::DATA_WIDTH-9:0]  imm,
    input  logic                            use_imm,
    output logic [cpu_pkg::DATA_WIDTH-1:0]  result
);

    // second operand
    logic [cpu_pkg::DATA_WIDTH-1:0] b;

    // immediate byte is zero-extended
    assign b = use_imm ? {{(cpu_pkg::DATA_WIDTH - 8){1'b0}}, imm} : mem_word;

    always_comb begin
        case (fn)
            cpu_pkg::ALU_ADD: begin
                result = a + b;
            end
            cpu_pkg::ALU_SUB: begin
                result = a - b;
            end
            // low half of the product only
            cpu_pkg::ALU_MUL: begin
                result = a * b;
            end
            // divide by zero saturates to all ones
            cpu_pkg::ALU_DIV: begin
                result = (b == '0) ? '1 : a / b;
            end
            // single-bit shifts, b ignored
            cpu_pkg::ALU_SHL: begin
                result = a << 1;
            end
            cpu_pkg::ALU_SHR: begin
                result = a >> 1;
            end
            // rotate by one through the word
            cpu_pkg::ALU_ROL: begin
                result = {a[cpu_pkg::DATA_WIDTH-2:0], a[cpu_pkg::DATA_WIDTH-1]};
            end
            cpu_pkg::ALU_ROR: begin
                result = {a[0], a[cpu_pkg::DATA_WIDTH-1:1]};
            end
            cpu_pkg::ALU_AND: begin
                result = a & b;
            end
            cpu_pkg::ALU_OR: begin
                result = a | b;
            end
            cpu_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            cpu_pkg::ALU_NOR: begin
                result = ~(a | b);
            end
            cpu_pkg::ALU_NAND: begin
                result = ~(a & b);
            end
            cpu_pkg::ALU_XNOR: begin
                result = ~(a ^ b);
            end
            // compares give 1 or 0
            cpu_pkg::ALU_GT: begin
                result = (a > b) ? 1 : 0;
            end
            default: begin
                result = (a == b) ? 1 : 0;
            end
        endcase
    end

endmodule

// File: rtl/register_bank.sv
module register_bank #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            pc_load,
    input  logic                            pc_inc,
    input  logic                            ir_load,
    input  logic                            acc_load,
    input  logic                            acc_src_mem,
    input  logic                            addr_sel_ir,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  mem_rdata,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  alu_result,
    output logic [cpu_pkg::DATA_WIDTH-1:0]  acc,
    output cpu_pkg::instr_t                 ir,
    output logic [ADDR_WIDTH-1:0]           mem_addr
);

    // program counter, as wide as the memory
    logic [ADDR_WIDTH-1:0] pc;

    // address field of the ir, high bits dropped for small memories
    logic [ADDR_WIDTH-1:0] ir_addr;

    // next accumulator value
    logic [cpu_pkg::DATA_WIDTH-1:0] acc_next;

    assign ir_addr = ir.mem.addr[ADDR_WIDTH-1:0];

    // lda takes the memory word, everything else the alu
    assign acc_next = acc_src_mem ? mem_rdata : alu_result;

    // pc during fetch, operand address during execute
    assign mem_addr = addr_sel_ir ? ir_addr : pc;

    // accumulator
    always_ff @(posedge clock) begin
        if (rst) begin
            acc <= '0;
        end else if (acc_load) begin
            acc <= acc_next;
        end
    end

    // program counter
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_load) begin
            // jump target straight from the ir
            pc <= ir_addr;
        end else if (pc_inc) begin
            // wraps at the top of memory
            pc <= pc + 1'b1;
        end
    end

    // instruction register
    // memory output register is the buffer, no separate mbr
    always_ff @(posedge clock) begin
        if (rst) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= mem_rdata;
        end
    end

endmodule

// File: rtl/main_memory.sv
module main_memory #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                            clock,
    input  logic                            cpu_write,
    input  logic [ADDR_WIDTH-1:0]           cpu_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  cpu_wdata,
    input  logic                            load_en,
    input  logic [ADDR_WIDTH-1:0]           load_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  load_data,
    input  logic                            load_allow,
    output logic [cpu_pkg::DATA_WIDTH-1:0]  rdata
);

    // word array, one word per address
    logic [cpu_pkg::DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // write port
    always_ff @(posedge clock) begin
        if (cpu_write) begin
            // cpu store wins
            mem[cpu_addr] <= cpu_wdata;
        end else if (load_en && load_allow) begin
            // program load only while idle
            mem[load_addr] <= load_data;
        end
    end

    // registered read every cycle
    // old data is returned on a same-address write
    always_ff @(posedge clock) begin
        rdata <= mem[cpu_addr];
    end

endmodule

// File: rtl/control_unit.sv
module control_unit (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            run,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  acc,
    input  cpu_pkg::instr_t                 ir,
    output logic                            pc_load,
    output logic                            pc_inc,
    output logic                            ir_load,
    output logic                            acc_load,
    output logic                            acc_src_mem,
    output logic                            addr_sel_ir,
    output logic                            mem_write,
    output cpu_pkg::alu_fn_t                alu_fn,
    output logic                            alu_use_imm,
    output logic                            load_allow,
    output logic                            out_valid,
    output logic                            halted
);

    cpu_pkg::state_t  state;
    cpu_pkg::state_t  next_state;
    cpu_pkg::opcode_t opcode;

    // lda and the memory alu ops need a second memory cycle
    logic needs_wb;

    // jz condition
    logic acc_zero;

    // both forms share the opcode field
    assign opcode = ir.mem.opcode;
    assign acc_zero = (acc == '0);

    assign needs_wb = (opcode == cpu_pkg::OP_LDA) || (opcode == cpu_pkg::OP_ADD) ||
                      (opcode == cpu_pkg::OP_SUB) || (opcode == cpu_pkg::OP_AND) ||
                      (opcode == cpu_pkg::OP_OR)  || (opcode == cpu_pkg::OP_XOR);

    assign load_allow = (state == cpu_pkg::ST_IDLE);
    assign halted = (state == cpu_pkg::ST_HALTED);

    // opi reads the function from the immediate view
    assign alu_use_imm = (opcode == cpu_pkg::OP_OPI);

    // alu function, memory ops mapped onto the alu codes
    always_comb begin
        case (opcode)
            cpu_pkg::OP_SUB: alu_fn = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND: alu_fn = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR:  alu_fn = cpu_pkg::ALU_OR;
            cpu_pkg::OP_XOR: alu_fn = cpu_pkg::ALU_XOR;
            cpu_pkg::OP_OPI: alu_fn = ir.imm.fn;
            default:         alu_fn = cpu_pkg::ALU_ADD;
        endcase
    end

    // next state and per-state enables
    always_comb begin
        next_state  = state;
        pc_load     = 1'b0;
        pc_inc      = 1'b0;
        ir_load     = 1'b0;
        acc_load    = 1'b0;
        acc_src_mem = 1'b0;
        addr_sel_ir = 1'b0;
        mem_write   = 1'b0;
        case (state)
            cpu_pkg::ST_IDLE: begin
                if (run) begin
                    next_state = cpu_pkg::ST_FETCH;
                end
            end
            // memory addressed by pc here
            cpu_pkg::ST_FETCH: begin
                next_state = cpu_pkg::ST_DECODE;
            end
            // fetched word now on the memory output
            cpu_pkg::ST_DECODE: begin
                ir_load    = 1'b1;
                pc_inc     = 1'b1;
                next_state = cpu_pkg::ST_EXECUTE;
            end
            cpu_pkg::ST_EXECUTE: begin
                // operand address for lda, sta and memory alu ops
                addr_sel_ir = needs_wb || (opcode == cpu_pkg::OP_STA);
                mem_write   = (opcode == cpu_pkg::OP_STA);
                pc_load     = (opcode == cpu_pkg::OP_JMP) ||
                              ((opcode == cpu_pkg::OP_JZ) && acc_zero);
                acc_load    = (opcode == cpu_pkg::OP_OPI);
                if (opcode == cpu_pkg::OP_HLT) begin
                    next_state = cpu_pkg::ST_HALTED;
                end else if (needs_wb) begin
                    next_state = cpu_pkg::ST_WRITEBACK;
                end else begin
                    next_state = cpu_pkg::ST_FETCH;
                end
            end
            // operand word arrives one cycle after its address
            cpu_pkg::ST_WRITEBACK: begin
                acc_load    = 1'b1;
                acc_src_mem = (opcode == cpu_pkg::OP_LDA);
                next_state  = cpu_pkg::ST_FETCH;
            end
            // parked until reset
            default: begin
                next_state = cpu_pkg::ST_HALTED;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= cpu_pkg::ST_IDLE;
            out_valid <= 1'b0;
        end else begin
            state     <= next_state;
            // strobe lands the cycle after out executes
            out_valid <= (state == cpu_pkg::ST_EXECUTE) && (opcode == cpu_pkg::OP_OUT);
        end
    end

endmodule

// File: rtl/accumulator_cpu.sv
module accumulator_cpu #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            run,
    input  logic                            load_en,
    input  logic [ADDR_WIDTH-1:0]           load_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  load_data,
    output logic                            out_valid,
    output logic [cpu_pkg::DATA_WIDTH-1:0]  out_data,
    output logic                            halted
);

    // control enables
    logic             pc_load;
    logic             pc_inc;
    logic             ir_load;
    logic             acc_load;
    logic             acc_src_mem;
    logic             addr_sel_ir;
    logic             mem_write;
    logic             alu_use_imm;
    logic             load_allow;
    cpu_pkg::alu_fn_t alu_fn;

    // datapath
    logic [cpu_pkg::DATA_WIDTH-1:0] acc;
    logic [cpu_pkg::DATA_WIDTH-1:0] mem_rdata;
    logic [cpu_pkg::DATA_WIDTH-1:0] alu_result;
    logic [ADDR_WIDTH-1:0]          mem_addr;
    cpu_pkg::instr_t                ir;

    // out carries the accumulator as is
    assign out_data = acc;

    control_unit u_control_unit (
        .clock       (clock),
        .rst         (rst),
        .run         (run),
        .acc         (acc),
        .ir          (ir),
        .pc_load     (pc_load),
        .pc_inc      (pc_inc),
        .ir_load     (ir_load),
        .acc_load    (acc_load),
        .acc_src_mem (acc_src_mem),
        .addr_sel_ir (addr_sel_ir),
        .mem_write   (mem_write),
        .alu_fn      (alu_fn),
        .alu_use_imm (alu_use_imm),
        .load_allow  (load_allow),
        .out_valid   (out_valid),
        .halted      (halted)
    );

    register_bank #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_register_bank (
        .clock       (clock),
        .rst         (rst),
        .pc_load     (pc_load),
        .pc_inc      (pc_inc),
        .ir_load     (ir_load),
        .acc_load    (acc_load),
        .acc_src_mem (acc_src_mem),
        .addr_sel_ir (addr_sel_ir),
        .mem_rdata   (mem_rdata),
        .alu_result  (alu_result),
        .acc         (acc),
        .ir          (ir),
        .mem_addr    (mem_addr)
    );

    // operand b is picked inside the alu
    alu u_alu (
        .fn       (alu_fn),
        .a        (acc),
        .mem_word (mem_rdata),
        .imm      (ir.imm.imm),
        .use_imm  (alu_use_imm),
        .result   (alu_result)
    );

    main_memory #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_main_memory (
        .clock      (clock),
        .cpu_write  (mem_write),
        .cpu_addr   (mem_addr),
        .cpu_wdata  (acc),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .load_allow (load_allow),
        .rdata      (mem_rdata)
    );

endmodule

// File: sim/cpu_sva.sv
module cpu_sva (
    input logic clock,
    input logic rst,
    input logic out_valid,
    input logic halted,
    input logic mem_write
);

    timeunit 1ns;
    timeprecision 100ps;

    // per-property failure counts
    int hold_fail = 0;
    int pulse_fail = 0;
    int halt_out_fail = 0;
    int halt_write_fail = 0;

    // total, read by the testbench at the end
    int fail_count;

    assign fail_count = hold_fail + pulse_fail + halt_out_fail + halt_write_fail;

    // halted is sticky until reset
    halted_sticky: assert property (@(posedge clock) disable iff (rst) halted |=> halted)
    else begin
        hold_fail++;
        $error("halted dropped while reset was low");
    end

    // out strobe is a single-cycle pulse
    out_single_pulse: assert property (@(posedge clock) disable iff (rst)
        out_valid |=> !out_valid)
    else begin
        pulse_fail++;
        $error("out_valid high in two consecutive cycles");
    end

    // a parked machine produces nothing
    no_out_when_halted: assert property (@(posedge clock) disable iff (rst)
        !(out_valid && halted))
    else begin
        halt_out_fail++;
        $error("out_valid high while halted");
    end

    // and stores nothing
    no_write_when_halted: assert property (@(posedge clock) disable iff (rst)
        !(mem_write && halted))
    else begin
        halt_write_fail++;
        $error("memory write while halted");
    end

endmodule

// File: sim/tb_accumulator_cpu.sv
module tb_accumulator_cpu;

    timeunit 1ns;
    timeprecision 100ps;

    // small memory, upper address bits of instructions are ignored
    localparam int ADDR_WIDTH = 8;
    localparam int IMAGE_WORDS = 128;
    // operands live above the code
    localparam int DATA_BASE = 100;
    localparam int HALT_TIMEOUT = 2000;

    // instruction classes
    localparam logic [3:0] OP_HLT = 4'h0;
    localparam logic [3:0] OP_LDA = 4'h1;
    localparam logic [3:0] OP_STA = 4'h2;
    localparam logic [3:0] OP_ADD = 4'h3;
    localparam logic [3:0] OP_SUB = 4'h4;
    localparam logic [3:0] OP_AND = 4'h5;
    localparam logic [3:0] OP_OR  = 4'h6;
    localparam logic [3:0] OP_XOR = 4'h7;
    localparam logic [3:0] OP_JMP = 4'h8;
    localparam logic [3:0] OP_JZ  = 4'h9;
    localparam logic [3:0] OP_OUT = 4'ha;
    localparam logic [3:0] OP_OPI = 4'hf;

    logic                  clock;
    logic                  rst;
    logic                  run;
    logic                  load_en;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [15:0]           load_data;
    logic                  out_valid;
    logic [15:0]           out_data;
    logic                  halted;

    // program image and the outputs it should produce
    logic [15:0] image [IMAGE_WORDS];
    logic [15:0] expected [$];
    int          code_ptr;
    int          seed = 32'hca16_5496;
    int          mismatch_count;
    int          other_count;

    accumulator_cpu #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_accumulator_cpu (
        .clock     (clock),
        .rst       (rst),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    bind accumulator_cpu cpu_sva u_cpu_sva (
        .clock     (clock),
        .rst       (rst),
        .out_valid (out_valid),
        .halted    (halted),
        .mem_write (mem_write)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    function automatic logic [15:0] mem_instr(input logic [3:0] op, input int addr);
        return {op, 12'(addr)};
    endfunction

    function automatic logic [15:0] imm_instr(input logic [3:0] fn, input logic [7:0] imm);
        return {OP_OPI, fn, imm};
    endfunction

    // reference alu, straight from the function table
    function automatic logic [15:0] alu_ref(input logic [3:0] fn, input logic [15:0] a,
                                            input logic [15:0] b);
        case (fn)
            4'h0: return a + b;
            4'h1: return a - b;
            4'h2: return a * b;
            4'h3: return (b == 16'h0) ? 16'hffff : a / b;
            4'h4: return {a[14:0], 1'b0};
            4'h5: return {1'b0, a[15:1]};
            4'h6: return {a[14:0], a[15]};
            4'h7: return {a[0], a[15:1]};
            4'h8: return a & b;
            4'h9: return a | b;
            4'ha: return a ^ b;
            4'hb: return ~(a | b);
            4'hc: return ~(a & b);
            4'hd: return ~(a ^ b);
            4'he: return (a > b) ? 16'd1 : 16'd0;
            default: return (a == b) ? 16'd1 : 16'd0;
        endcase
    endfunction

    task automatic emit(input logic [15:0] word);
        image[code_ptr] = word;
        code_ptr++;
    endtask

    task automatic clear_image();
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            image[i] = 16'h0000;
        end
        code_ptr = 0;
        expected.delete();
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #1;
        rst = 1'b1;
        run = 1'b0;
        load_en = 1'b0;
        repeat (16) @(posedge clock);
        #1;
        rst = 1'b0;
    endtask

    // whole image, one word per cycle, machine idle
    task automatic load_program();
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            @(posedge clock);
            #1;
            load_en = 1'b1;
            load_addr = ADDR_WIDTH'(i);
            load_data = image[i];
        end
        @(posedge clock);
        #1;
        load_en = 1'b0;
    endtask

    task automatic start_run();
        @(posedge clock);
        #1;
        run = 1'b1;
    endtask

    // bounded wait for halted, then a quiet window
    task automatic finish_program(input string name);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("%s: halted did not rise within %0d cycles", name, HALT_TIMEOUT);
            other_count++;
        end else begin
            // any out_valid here is caught by the output monitor
            repeat (50) begin
                @(posedge clock);
                #1;
                if (!halted) begin
                    $display("%s: halted dropped during the quiet window", name);
                    other_count++;
                end
            end
        end
        if (expected.size() != 0) begin
            $display("%s: %0d expected outputs never appeared", name, expected.size());
            other_count++;
        end
    endtask

    task automatic run_image(input string name);
        apply_reset();
        load_program();
        start_run();
        finish_program(name);
    endtask

    // lda, sta to a fresh word, lda back, out
    task automatic build_load_store();
        clear_image();
        image[DATA_BASE] = 16'($random(seed));
        image[DATA_BASE + 1] = ~image[DATA_BASE];
        emit(mem_instr(OP_LDA, DATA_BASE));
        emit(mem_instr(OP_STA, DATA_BASE + 1));
        emit(mem_instr(OP_LDA, DATA_BASE + 1));
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_HLT, 0));
        expected.push_back(image[DATA_BASE]);
    endtask

    task automatic add_imm_case(input int slot, input logic [3:0] fn, input logic [15:0] a,
                                input logic [7:0] imm);
        image[DATA_BASE + slot] = a;
        emit(mem_instr(OP_LDA, DATA_BASE + slot));
        emit(imm_instr(fn, imm));
        emit(mem_instr(OP_OUT, 0));
        expected.push_back(alu_ref(fn, a, {8'h00, imm}));
    endtask

    task automatic check_immediate();
        logic [7:0] imm;
        clear_image();
        for (int fn = 0; fn < 16; fn++) begin
            add_imm_case(fn, 4'(fn), 16'($random(seed)), 8'($random(seed)));
        end
        // divide by zero, a false compare and a true equal
        add_imm_case(16, 4'h3, 16'($random(seed)), 8'h00);
        add_imm_case(17, 4'he, 16'h0005, 8'h09);
        imm = 8'($random(seed));
        add_imm_case(18, 4'hf, {8'h00, imm}, imm);
        emit(mem_instr(OP_HLT, 0));
        run_image("immediate");
    endtask

    // chained memory-operand ops, out after each
    task automatic check_memory_alu();
        logic [3:0]  op_list [5];
        logic [3:0]  fn_list [5];
        logic [15:0] acc_model;
        logic [15:0] operand;
        op_list = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        fn_list = '{4'h0, 4'h1, 4'h8, 4'h9, 4'ha};
        clear_image();
        acc_model = 16'($random(seed));
        image[DATA_BASE] = acc_model;
        emit(mem_instr(OP_LDA, DATA_BASE));
        for (int i = 0; i < 5; i++) begin
            operand = 16'($random(seed));
            image[DATA_BASE + 1 + i] = operand;
            emit(mem_instr(op_list[i], DATA_BASE + 1 + i));
            emit(mem_instr(OP_OUT, 0));
            acc_model = alu_ref(fn_list[i], acc_model, operand);
            expected.push_back(acc_model);
        end
        emit(mem_instr(OP_HLT, 0));
        run_image("memory alu");
    endtask

    // countdown from n, both jz outcomes
    task automatic check_countdown();
        int n;
        clear_image();
        n = 3 + ({$random(seed)} % 8);
        image[DATA_BASE] = 16'(n);
        image[DATA_BASE + 1] = 16'd1;
        emit(mem_instr(OP_LDA, DATA_BASE));
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_SUB, DATA_BASE + 1));
        emit(mem_instr(OP_JZ, 5));
        emit(mem_instr(OP_JMP, 1));
        emit(mem_instr(OP_HLT, 0));
        for (int k = n; k >= 1; k--) begin
            expected.push_back(16'(k));
        end
        run_image("countdown");
    endtask

    // load strobe on the operand word while fetching, must be dropped
    task automatic check_load_gating();
        build_load_store();
        apply_reset();
        load_program();
        start_run();
        @(posedge clock);
        #1;
        load_en = 1'b1;
        load_addr = ADDR_WIDTH'(DATA_BASE);
        load_data = ~image[DATA_BASE];
        @(posedge clock);
        #1;
        load_en = 1'b0;
        finish_program("load gating");
    endtask

    // output monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (!rst && out_valid) begin
            if (expected.size() == 0) begin
                $display("unexpected out_valid at %0t ns, out_data %h", $time, out_data);
                other_count++;
            end else begin
                if (out_data !== expected[0]) begin
                    $display("mismatch at %0t ns: out_data expected %h actual %h",
                             $time, expected[0], out_data);
                    mismatch_count++;
                end
                void'(expected.pop_front());
            end
        end
    end

    initial begin
        int assertion_count;
        rst = 1'b1;
        run = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        mismatch_count = 0;
        other_count = 0;
        build_load_store();
        run_image("load store");
        check_immediate();
        check_memory_alu();
        check_countdown();
        check_load_gating();
        assertion_count = u_accumulator_cpu.u_cpu_sva.fail_count;
        $display("errors: %0d mismatch, %0d other, %0d assertion",
                 mismatch_count, other_count, assertion_count);
        if (mismatch_count == 0 && other_count == 0 && assertion_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/register_bank.sv
rtl/main_memory.sv
rtl/control_unit.sv
rtl/accumulator_cpu.sv
sim/cpu_sva.sv
sim/tb_accumulator_cpu.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_accumulator_cpu -f compile.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
